// File: verilog/gfx_pkg.sv
package gfx_pkg;

  // command word layout, msb first: opcode, x0, y0, x1, y1, color
  localparam int OPCODE_W = 2;
  localparam int COORD_W  = 10;
  localparam int COLOR_W  = 12;

  localparam int CMD_WIDTH = OPCODE_W + 4 * COORD_W + COLOR_W;

  localparam int COLOR_LSB = 0;
  localparam int Y1_LSB    = COLOR_LSB + COLOR_W;
  localparam int X1_LSB    = Y1_LSB + COORD_W;
  localparam int Y0_LSB    = X1_LSB + COORD_W;
  localparam int X0_LSB    = Y0_LSB + COORD_W;
  localparam int OP_LSB    = X0_LSB + COORD_W;

  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [CMD_WIDTH-1:0] cmd_t;

  localparam opcode_t OP_NOP       = 2'd0;
  localparam opcode_t OP_FILL_RECT = 2'd1;
  localparam opcode_t OP_PLOT      = 2'd2;
  localparam opcode_t OP_CLEAR     = 2'd3;  // whole screen, corners ignored

endpackage

// File: verilog/gfx_rect_if.sv
`timescale 1ns/1ps

interface gfx_rect_if #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12
);

  logic                   start;  // one job at a time
  logic                   done;
  logic [H_WIDTH-1:0]     x0;
  logic [V_WIDTH-1:0]     y0;
  logic [H_WIDTH-1:0]     x1;
  logic [V_WIDTH-1:0]     y1;
  logic [PIXEL_WIDTH-1:0] color;

  // corners and color stay put from start until done
  modport decoder (
    output start, x0, y0, x1, y1, color,
    input  done
  );

  modport filler (
    input  start, x0, y0, x1, y1, color,
    output done
  );

endinterface

// File: verilog/gfx_pixel_if.sv
`timescale 1ns/1ps

interface gfx_pixel_if #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12
);

  logic                   valid;
  logic                   ready;
  logic [H_WIDTH-1:0]     x;
  logic [V_WIDTH-1:0]     y;
  logic [PIXEL_WIDTH-1:0] pixel;

  modport manager (output valid, x, y, pixel, input ready);

  modport subordinate (input valid, x, y, pixel, output ready);

endinterface

// File: verilog/gfx_cmd_decode.sv
`timescale 1ns/1ps

module gfx_cmd_decode #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12,
  parameter int H_RES       = 640,
  parameter int V_RES       = 480
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  input  gfx_pkg::cmd_t      cmd_word,
  input  logic               drained,
  output logic               busy,
  output logic               cmd_dropped,
  output logic               done,
  gfx_rect_if.decoder        rect
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } state_t;

  state_t state;

  gfx_pkg::opcode_t       opcode;
  logic                   is_cmd;
  logic                   accept;
  logic [H_WIDTH-1:0]     f_x0;
  logic [V_WIDTH-1:0]     f_y0;
  logic [H_WIDTH-1:0]     f_x1;
  logic [V_WIDTH-1:0]     f_y1;
  logic [PIXEL_WIDTH-1:0] f_color;

  assign opcode  = cmd_word[gfx_pkg::OP_LSB +: gfx_pkg::OPCODE_W];
  assign f_x0    = H_WIDTH'(cmd_word[gfx_pkg::X0_LSB +: gfx_pkg::COORD_W]);
  assign f_y0    = V_WIDTH'(cmd_word[gfx_pkg::Y0_LSB +: gfx_pkg::COORD_W]);
  assign f_x1    = H_WIDTH'(cmd_word[gfx_pkg::X1_LSB +: gfx_pkg::COORD_W]);
  assign f_y1    = V_WIDTH'(cmd_word[gfx_pkg::Y1_LSB +: gfx_pkg::COORD_W]);
  assign f_color = PIXEL_WIDTH'(cmd_word[gfx_pkg::COLOR_LSB +: gfx_pkg::COLOR_W]);

  assign is_cmd = cmd_valid && (opcode != gfx_pkg::OP_NOP);  // nop never counts
  assign accept = is_cmd && (state == ST_IDLE);
  assign busy   = (state != ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      rect.start  <= 1'b0;
      cmd_dropped <= 1'b0;
      done        <= 1'b0;
    end else begin
      rect.start  <= accept;
      cmd_dropped <= is_cmd && busy;
      done        <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) state <= ST_RUN;
        end
        ST_RUN: begin
          if (rect.done) begin
            // clip slot may still hold the last pixel
            state <= drained ? ST_IDLE : ST_DRAIN;
            done  <= drained;
          end
        end
        ST_DRAIN: begin
          if (drained) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // job fields, held until the next accepted command
  always_ff @(posedge clk) begin
    if (accept) begin
      rect.color <= f_color;
      case (opcode)
        gfx_pkg::OP_PLOT: begin
          rect.x0 <= f_x0;
          rect.y0 <= f_y0;
          rect.x1 <= f_x0;  // degenerate 1x1 rect
          rect.y1 <= f_y0;
        end
        gfx_pkg::OP_CLEAR: begin
          rect.x0 <= '0;
          rect.y0 <= '0;
          rect.x1 <= H_WIDTH'(H_RES - 1);
          rect.y1 <= V_WIDTH'(V_RES - 1);
        end
        default: begin
          rect.x0 <= f_x0;
          rect.y0 <= f_y0;
          rect.x1 <= f_x1;
          rect.y1 <= f_y1;
        end
      endcase
    end
  end

  // no second start before the job has fully left the engine
  a_one_job: assert property (@(posedge clk) disable iff (!rst_n)
    rect.start |=> (!rect.start until_with done));

endmodule

// File: verilog/gfx_rect_fill.sv
`timescale 1ns/1ps

module gfx_rect_fill #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12
) (
  input  logic          clk,
  input  logic          rst_n,
  gfx_rect_if.filler    rect,
  gfx_pixel_if.manager  gfx
);

  typedef logic [H_WIDTH-1:0] x_t;
  typedef logic [V_WIDTH-1:0] y_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_FILLING,
    ST_FINISH
  } state_t;

  state_t state;

  x_t   x_min;
  x_t   x_max;
  y_t   y_min;
  y_t   y_max;
  x_t   curr_x;
  y_t   curr_y;
  logic x_swap;
  logic y_swap;
  logic load;
  logic row_end;
  logic last;

  assign x_swap = (rect.x1 < rect.x0);
  assign y_swap = (rect.y1 < rect.y0);

  // output register free or being taken this cycle
  assign load    = (state == ST_FILLING) && (!gfx.valid || gfx.ready);
  assign row_end = (curr_x == x_max);
  assign last    = row_end && (curr_y == y_max);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      gfx.valid <= 1'b0;
      rect.done <= 1'b0;
    end else begin
      rect.done <= 1'b0;
      if (gfx.ready) gfx.valid <= 1'b0;  // taken downstream

      case (state)
        ST_IDLE: begin
          if (rect.start) state <= ST_SETUP;
        end
        ST_SETUP: begin
          state <= ST_FILLING;
        end
        ST_FILLING: begin
          if (load) begin
            gfx.valid <= 1'b1;
            if (last) state <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          // wait for the last pixel to leave
          if (gfx.valid && gfx.ready) begin
            rect.done <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_SETUP) begin
      x_min  <= x_swap ? rect.x1 : rect.x0;
      x_max  <= x_swap ? rect.x0 : rect.x1;
      y_min  <= y_swap ? rect.y1 : rect.y0;
      y_max  <= y_swap ? rect.y0 : rect.y1;
      curr_x <= x_swap ? rect.x1 : rect.x0;
      curr_y <= y_swap ? rect.y1 : rect.y0;
    end

    if (load) begin
      gfx.x     <= curr_x;
      gfx.y     <= curr_y;
      gfx.pixel <= rect.color;  // held by decode until done
      if (row_end) begin
        curr_x <= x_min;
        curr_y <= curr_y + 1'b1;
      end else begin
        curr_x <= curr_x + 1'b1;
      end
    end
  end

  // stalled pixel must not change under the consumer
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    gfx.valid && !gfx.ready |=>
      gfx.valid && $stable(gfx.x) && $stable(gfx.y) && $stable(gfx.pixel));

  // walk stays inside the box latched at setup
  a_in_box: assert property (@(posedge clk) disable iff (!rst_n)
    gfx.valid |-> (gfx.x >= x_min) && (gfx.x <= x_max) &&
                  (gfx.y >= y_min) && (gfx.y <= y_max));

endmodule

// File: verilog/gfx_clip_stage.sv
`timescale 1ns/1ps

module gfx_clip_stage #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12,
  parameter int H_RES       = 640,
  parameter int V_RES       = 480
) (
  input  logic                   clk,
  input  logic                   rst_n,
  gfx_pixel_if.subordinate       in,
  output logic                   pix_valid,
  output logic [H_WIDTH-1:0]     pix_x,
  output logic [V_WIDTH-1:0]     pix_y,
  output logic [PIXEL_WIDTH-1:0] pix_color,
  input  logic                   pix_ready,
  output logic                   drained
);

  // one extra bit so a full-range resolution still compares right
  localparam logic [H_WIDTH:0] H_LIMIT = (H_WIDTH + 1)'(H_RES);
  localparam logic [V_WIDTH:0] V_LIMIT = (V_WIDTH + 1)'(V_RES);

  logic on_screen;
  logic take;

  assign on_screen = ({1'b0, in.x} < H_LIMIT) && ({1'b0, in.y} < V_LIMIT);

  // slot empty or emptying this cycle
  assign in.ready = !pix_valid || pix_ready;
  assign take     = in.valid && in.ready && on_screen;
  assign drained  = !pix_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
    end else if (in.ready) begin
      pix_valid <= take;  // off-screen input just vanishes
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pix_x     <= in.x;
      pix_y     <= in.y;
      pix_color <= in.pixel;
    end
  end

  a_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid |-> ({1'b0, pix_x} < H_LIMIT) && ({1'b0, pix_y} < V_LIMIT));

endmodule

// File: verilog/gfx_engine_top.sv
`timescale 1ns/1ps

module gfx_engine_top #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12,
  parameter int H_RES       = 640,
  parameter int V_RES       = 480
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  input  gfx_pkg::cmd_t          cmd_word,
  output logic                   busy,
  output logic                   cmd_dropped,
  output logic                   done,
  output logic                   pix_valid,
  output logic [H_WIDTH-1:0]     pix_x,
  output logic [V_WIDTH-1:0]     pix_y,
  output logic [PIXEL_WIDTH-1:0] pix_color,
  input  logic                   pix_ready
);

  logic drained;

  gfx_rect_if #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) rect_bus ();

  gfx_pixel_if #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) pix_bus ();

  gfx_cmd_decode #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH),
    .H_RES      (H_RES),
    .V_RES      (V_RES)
  ) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .drained    (drained),
    .busy       (busy),
    .cmd_dropped(cmd_dropped),
    .done       (done),
    .rect       (rect_bus)
  );

  gfx_rect_fill #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) u_fill (
    .clk  (clk),
    .rst_n(rst_n),
    .rect (rect_bus),
    .gfx  (pix_bus)
  );

  gfx_clip_stage #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH),
    .H_RES      (H_RES),
    .V_RES      (V_RES)
  ) u_clip (
    .clk      (clk),
    .rst_n    (rst_n),
    .in       (pix_bus),
    .pix_valid(pix_valid),
    .pix_x    (pix_x),
    .pix_y    (pix_y),
    .pix_color(pix_color),
    .pix_ready(pix_ready),
    .drained  (drained)
  );

endmodule

// File: verification/gfx_engine_checker.sv
`timescale 1ns/1ps

module gfx_engine_checker #(
  parameter int H_WIDTH     = 10,
  parameter int V_WIDTH     = 10,
  parameter int PIXEL_WIDTH = 12,
  parameter int H_RES       = 640,
  parameter int V_RES       = 480
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  input  gfx_pkg::cmd_t          cmd_word,
  input  logic                   done,
  input  logic                   cmd_dropped,
  input  logic                   pix_valid,
  input  logic [H_WIDTH-1:0]     pix_x,
  input  logic [V_WIDTH-1:0]     pix_y,
  input  logic [PIXEL_WIDTH-1:0] pix_color,
  input  logic                   pix_ready,
  output int                     error_count,
  output int                     pixel_count,
  output int                     drop_count
);

  int exp_x[$];
  int exp_y[$];
  int exp_color[$];
  bit model_busy;
  bit drop_due;  // a command hit a busy engine last cycle

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // expected stream of one accepted command, raster order from the top-left
  task automatic queue_pixels(input gfx_pkg::cmd_t word);
    gfx_pkg::opcode_t op;
    int x0, y0, x1, y1, color, tmp, x, y;
    op    = word[gfx_pkg::OP_LSB +: gfx_pkg::OPCODE_W];
    x0    = word[gfx_pkg::X0_LSB +: gfx_pkg::COORD_W];
    y0    = word[gfx_pkg::Y0_LSB +: gfx_pkg::COORD_W];
    x1    = word[gfx_pkg::X1_LSB +: gfx_pkg::COORD_W];
    y1    = word[gfx_pkg::Y1_LSB +: gfx_pkg::COORD_W];
    color = word[gfx_pkg::COLOR_LSB +: gfx_pkg::COLOR_W];
    if (op == gfx_pkg::OP_PLOT) begin
      x1 = x0;
      y1 = y0;
    end else if (op == gfx_pkg::OP_CLEAR) begin
      x0 = 0;
      y0 = 0;
      x1 = H_RES - 1;
      y1 = V_RES - 1;
    end
    if (x1 < x0) begin
      tmp = x0;
      x0  = x1;
      x1  = tmp;
    end
    if (y1 < y0) begin
      tmp = y0;
      y0  = y1;
      y1  = tmp;
    end
    for (y = y0; y <= y1; y++) begin
      for (x = x0; x <= x1; x++) begin
        if (x < H_RES && y < V_RES) begin  // off-screen never leaves the engine
          exp_x.push_back(x);
          exp_y.push_back(y);
          exp_color.push_back(color);
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      model_busy  = 1'b0;
      drop_due    = 1'b0;
      error_count = 0;
      pixel_count = 0;
      drop_count  = 0;
      exp_x.delete();
      exp_y.delete();
      exp_color.delete();
    end else begin
      if (cmd_dropped !== drop_due)
        report_mismatch($sformatf("cmd_dropped is %b, expected %b", cmd_dropped, drop_due));
      if (cmd_dropped)
        drop_count++;

      if (pix_valid && pix_ready) begin
        pixel_count++;
        if (exp_x.size() == 0) begin
          report_mismatch($sformatf("unexpected pixel at (%0d,%0d)", pix_x, pix_y));
        end else begin
          if (int'(pix_x) != exp_x[0] || int'(pix_y) != exp_y[0] ||
              int'(pix_color) != exp_color[0])
            report_mismatch($sformatf("pixel (%0d,%0d) color %h, expected (%0d,%0d) color %h",
                                      pix_x, pix_y, pix_color,
                                      exp_x[0], exp_y[0], exp_color[0]));
          void'(exp_x.pop_front());
          void'(exp_y.pop_front());
          void'(exp_color.pop_front());
        end
      end

      if (done) begin
        if (!model_busy)
          report_mismatch("done pulsed with no command in flight");
        else if (exp_x.size() != 0)
          report_mismatch($sformatf("done with %0d pixels still missing", exp_x.size()));
        model_busy = 1'b0;  // engine is idle again from this cycle
      end

      drop_due = 1'b0;
      if (cmd_valid && cmd_word[gfx_pkg::OP_LSB +: gfx_pkg::OPCODE_W] != gfx_pkg::OP_NOP) begin
        if (model_busy) begin
          drop_due = 1'b1;
        end else begin
          model_busy = 1'b1;
          queue_pixels(cmd_word);
        end
      end
    end
  end

endmodule

// File: verification/gfx_engine_tb.sv
`timescale 1ns/1ps

module gfx_engine_tb;

  localparam int H_WIDTH     = 10;
  localparam int V_WIDTH     = 10;
  localparam int PIXEL_WIDTH = 12;
  localparam int H_RES       = 16;  // small screen keeps the clear test short
  localparam int V_RES       = 8;
  localparam int MAX_TESTS   = 32;
  localparam int TIMEOUT     = 4000;

  typedef logic [gfx_pkg::COORD_W-1:0] coord_t;
  typedef logic [gfx_pkg::COLOR_W-1:0] color_t;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid;
  gfx_pkg::cmd_t          cmd_word;
  logic                   busy;
  logic                   cmd_dropped;
  logic                   done;
  logic                   pix_valid;
  logic [H_WIDTH-1:0]     pix_x;
  logic [V_WIDTH-1:0]     pix_y;
  logic [PIXEL_WIDTH-1:0] pix_color;
  logic                   pix_ready;

  int error_count;
  int pixel_count;
  int drop_count;
  int seed = 86552;
  int num_tests;
  int passed;
  int failed;
  int vec_op[MAX_TESTS];
  int vec_x0[MAX_TESTS];
  int vec_y0[MAX_TESTS];
  int vec_x1[MAX_TESTS];
  int vec_y1[MAX_TESTS];
  int vec_color[MAX_TESTS];
  int vec_npix[MAX_TESTS];
  int vec_probe[MAX_TESTS];

  gfx_engine_top #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH),
    .H_RES      (H_RES),
    .V_RES      (V_RES)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .busy       (busy),
    .cmd_dropped(cmd_dropped),
    .done       (done),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_color  (pix_color),
    .pix_ready  (pix_ready)
  );

  gfx_engine_checker #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH),
    .H_RES      (H_RES),
    .V_RES      (V_RES)
  ) chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .done       (done),
    .cmd_dropped(cmd_dropped),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_color  (pix_color),
    .pix_ready  (pix_ready),
    .error_count(error_count),
    .pixel_count(pixel_count),
    .drop_count (drop_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1;
    pix_ready = ($random(seed) & 3) != 0;  // stalls about one cycle in four
  end

  function automatic gfx_pkg::cmd_t pack_cmd(input int op, x0, y0, x1, y1, color);
    gfx_pkg::cmd_t w;
    w = '0;
    w[gfx_pkg::OP_LSB +: gfx_pkg::OPCODE_W]   = gfx_pkg::opcode_t'(op);
    w[gfx_pkg::X0_LSB +: gfx_pkg::COORD_W]    = coord_t'(x0);
    w[gfx_pkg::Y0_LSB +: gfx_pkg::COORD_W]    = coord_t'(y0);
    w[gfx_pkg::X1_LSB +: gfx_pkg::COORD_W]    = coord_t'(x1);
    w[gfx_pkg::Y1_LSB +: gfx_pkg::COORD_W]    = coord_t'(y1);
    w[gfx_pkg::COLOR_LSB +: gfx_pkg::COLOR_W] = color_t'(color);
    return w;
  endfunction

  // lines that do not parse to eight fields are comments
  task load_vectors();
    int fd;
    int n;
    logic [8*160-1:0] line;
    int op, x0, y0, x1, y1, color, npix, probe;
    num_tests = 0;
    fd = $fopen("verification/gfx_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/gfx_input_vectors.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %d %d %d %d %h %d %d", op, x0, y0, x1, y1, color, npix, probe);
        if (n == 8 && num_tests < MAX_TESTS) begin
          vec_op[num_tests]    = op;
          vec_x0[num_tests]    = x0;
          vec_y0[num_tests]    = y0;
          vec_x1[num_tests]    = x1;
          vec_y1[num_tests]    = y1;
          vec_color[num_tests] = color;
          vec_npix[num_tests]  = npix;
          vec_probe[num_tests] = probe;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task send_cmd(input gfx_pkg::cmd_t word);
    @(posedge clk);
    #1;
    cmd_valid = 1'b1;
    cmd_word  = word;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task wait_done(output bit ok);
    int cycles;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = done;
  endtask

  initial begin
    bit ok;
    bit test_ok;
    int i;
    int base_err, base_pix, base_drop, got_pix, got_drop;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_word  = '0;
    pix_ready = 1'b0;
    passed    = 0;
    failed    = 0;
    load_vectors();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    ok = (num_tests > 0);
    if (!ok)
      $display("no test vectors found, nothing was run");
    for (i = 0; i < num_tests && ok; i++) begin
      test_ok   = 1'b1;
      base_err  = error_count;
      base_pix  = pixel_count;
      base_drop = drop_count;
      send_cmd(pack_cmd(vec_op[i], vec_x0[i], vec_y0[i], vec_x1[i], vec_y1[i], vec_color[i]));
      if (!busy) begin
        $display("test %0d: busy did not rise after the command", i);
        test_ok = 1'b0;
      end
      if (vec_probe[i] != 0)
        send_cmd(pack_cmd(gfx_pkg::OP_PLOT, 0, 0, 0, 0, 'hfff));  // must be dropped
      wait_done(ok);
      if (!ok) begin
        $display("test %0d: timeout, done did not arrive within %0d cycles", i, TIMEOUT);
        failed++;
      end else begin
        @(posedge clk);  // checker sees done on this edge
        #1;
        got_pix  = pixel_count - base_pix;
        got_drop = drop_count - base_drop;
        if (got_pix != vec_npix[i]) begin
          $display("CHECK FAILED at %0t: test %0d expected %0d pixels, got %0d",
                   $time, i, vec_npix[i], got_pix);
          test_ok = 1'b0;
        end
        if (got_drop != vec_probe[i]) begin
          $display("CHECK FAILED at %0t: test %0d expected %0d dropped, got %0d",
                   $time, i, vec_probe[i], got_drop);
          test_ok = 1'b0;
        end
        if (error_count != base_err)
          test_ok = 1'b0;
        if (test_ok)
          passed++;
        else
          failed++;
        $display("test %0d op %0d: %s, %0d pixels", i, vec_op[i],
                 test_ok ? "pass" : "FAIL", got_pix);
      end
    end
    if (ok)
      repeat (20) @(posedge clk);  // stray pixels would show up here
    $display("tests passed: %0d, failed: %0d", passed, failed);
    if (ok && failed == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verification/gfx_input_vectors.txt
# op x0 y0 x1 y1 color(hex) expected_pixels drop_probe
# op 1 fill, 2 plot, 3 clear; the testbench screen is 16x8
1 9 5 3 2 abc 28 0
2 4 6 0 0 5a5 1 0
3 0 0 0 0 0f0 128 0
1 12 5 20 9 321 12 0
1 1 1 4 2 777 8 1
1 0 0 2 1 123 6 0
2 20 3 0 0 fff 0 0
1 15 7 0 0 a0a 128 0
1 3 3 3 3 444 1 0

// File: vlog.f
verilog/gfx_pkg.sv
verilog/gfx_rect_if.sv
verilog/gfx_pixel_if.sv
verilog/gfx_cmd_decode.sv
verilog/gfx_rect_fill.sv
verilog/gfx_clip_stage.sv
verilog/gfx_engine_top.sv
verification/gfx_engine_checker.sv
verification/gfx_engine_tb.sv

// File: Bender.yml
package:
  name: gfx_engine

sources:
  - files:
      - verilog/gfx_pkg.sv
      - verilog/gfx_rect_if.sv
      - verilog/gfx_pixel_if.sv
      - verilog/gfx_cmd_decode.sv
      - verilog/gfx_rect_fill.sv
      - verilog/gfx_clip_stage.sv
      - verilog/gfx_engine_top.sv
  - target: test
    files:
      - verification/gfx_engine_checker.sv
      - verification/gfx_engine_tb.sv
